// File: hdl/adpcm_pkg.sv
// Types and sizes shared by the ADPCM-A gain and pan stage; every RTL module imports this package
package adpcm_pkg;

    localparam int NUM_CH     = 6;      // Channel slots per rotation
    localparam int PCM_W      = 16;     // Decoded sample width
    localparam int GAIN_W     = 10;     // Linear gain, 512 is unity
    localparam int GAIN_SHIFT = 9;      // Drops the unity weight after the multiply
    localparam int LVL_W      = 6;      // Channel level and total level
    localparam int ATT_W      = 7;      // Two 6-bit attenuations added
    localparam int SUM_W      = 19;     // Room for six full-scale samples

    localparam logic [3:0] TL_ADDR = 4'd8;   // Total level register

    // Slot 0 to NUM_CH-1
    typedef logic [2:0] slot_t;

    typedef logic signed [PCM_W-1:0] pcm_t;

    typedef logic [GAIN_W-1:0] gain_t;

    // One channel's pan and level byte
    typedef struct packed {
        logic             l_en;     // Route to left
        logic             r_en;     // Route to right
        logic [LVL_W-1:0] level;    // 63 loudest
    } chan_ctl_t;

    // Total level as seen in the write byte
    typedef struct packed {
        logic [1:0]       pad;      // Ignored
        logic [LVL_W-1:0] tl;       // 63 loudest
    } tl_view_t;

    // CPU write byte, decoded by address
    typedef union packed {
        chan_ctl_t ch;              // Addresses 0 to 5
        tl_view_t  tot;             // Address 8
    } reg_data_u;

endpackage

// File: hdl/adpcm_db_rom.sv
// Registered attenuation-to-gain table, 0.75 dB per step; looked up by the gain pipeline at stage II
`timescale 1ns/1ps

module adpcm_db_rom import adpcm_pkg::*; (
    input  logic             clk,
    input  logic             cen,
    input  logic [LVL_W-1:0] db,    // Attenuation in 0.75 dB steps
    output gain_t            lin    // Valid one cen cycle after db
);

    // round(512 * 10^(-0.0375 * n)), one 6 dB octave per row
    localparam gain_t LUT [64] = '{
        10'd512, 10'd470, 10'd431, 10'd395, 10'd362, 10'd332, 10'd305, 10'd280,
        10'd257, 10'd235, 10'd216, 10'd198, 10'd182, 10'd167, 10'd153, 10'd140,
        10'd129, 10'd118, 10'd108, 10'd99,  10'd91,  10'd84,  10'd77,  10'd70,
        10'd64,  10'd59,  10'd54,  10'd50,  10'd46,  10'd42,  10'd38,  10'd35,
        10'd32,  10'd30,  10'd27,  10'd25,  10'd23,  10'd21,  10'd19,  10'd18,
        10'd16,  10'd15,  10'd14,  10'd12,  10'd11,  10'd11,  10'd10,  10'd9,
        10'd8,   10'd7,   10'd7,   10'd6,   10'd6,   10'd5,   10'd5,   10'd4,
        10'd4,   10'd4,   10'd3,   10'd3,   10'd3,   10'd3,   10'd2,   10'd2
    };

    // Registered read port, steps only with cen
    always_ff @(posedge clk) begin
        if (cen) begin
            lin <= LUT[db];
        end
    end

    // Zero attenuation must come back as unity on the next read
    a_unity: assert property (@(posedge clk)
        cen && db == '0 |=> lin == gain_t'(1 << GAIN_SHIFT));

endmodule

// File: hdl/adpcm_ctl_regs.sv
// CPU register block: holds pending pan/level bytes per channel and the total level, feeds the gain ring
`timescale 1ns/1ps

module adpcm_ctl_regs import adpcm_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cen,
    input  logic             wr,        // Single-cycle write strobe
    input  logic [3:0]       addr,
    input  reg_data_u        din,
    input  slot_t            slot,      // Channel now at stage IV
    output logic             load,      // Replace that channel's ring byte
    output chan_ctl_t        load_ctl,
    output logic [LVL_W-1:0] tl
);

    logic [NUM_CH-1:0] pend;            // Byte waiting for its slot
    chan_ctl_t         pend_ctl [NUM_CH];
    logic              ch_wr;           // Write to a channel address
    logic              tl_wr;

    assign ch_wr = wr && (addr < NUM_CH);
    assign tl_wr = wr && (addr == TL_ADDR);

    // Pending bytes, last write before the slot wins
    always_ff @(posedge clk) begin
        if (ch_wr) begin
            pend_ctl[addr[2:0]] <= din.ch;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= '0;
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (ch_wr && addr == i) begin
                    pend[i] <= 1'b1;            // Write beats a same-cycle load
                end else if (load && slot == i) begin
                    pend[i] <= 1'b0;            // Taken by the ring
                end
            end
        end
    end

    // Total level takes effect at once, no slot timing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tl <= '0;
        end else if (tl_wr) begin
            tl <= din.tot.tl;
        end
    end

    // Ring load only while the pipeline steps
    assign load     = cen && pend[slot];
    assign load_ctl = pend_ctl[slot];

    // Flag drops after the load unless the CPU wrote the same channel again
    a_load_clr: assert property (@(posedge clk) disable iff (!rst_n)
        load && !(ch_wr && addr == slot) |=> !pend[$past(slot)]);

endmodule

// File: hdl/adpcm_gain.sv
// Six-stage rotating gain pipeline: level to dB, ROM lookup, multiply and pan, one channel per cen
`timescale 1ns/1ps

module adpcm_gain import adpcm_pkg::*; #(
    parameter int NUM_CH = adpcm_pkg::NUM_CH
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cen,
    input  logic             load,      // New byte for the stage IV channel
    input  chan_ctl_t        load_ctl,
    input  logic [LVL_W-1:0] tl,        // Total level
    input  pcm_t             pcm_in,    // Sample for slot
    output slot_t            slot,
    output pcm_t             out_l,
    output pcm_t             out_r,
    output logic             out_stb,
    output slot_t            out_slot
);

    chan_ctl_t                    ctl1, ctl2, ctl3, ctl4, ctl5, ctl6;  // Control ring
    logic [ATT_W-1:0]             db2, db3;       // Summed attenuation
    gain_t                        lin3;           // ROM output
    gain_t                        gain4;          // Clamped gain for stage IV
    logic signed [PCM_W+GAIN_W:0] mul5;           // Full product
    logic [1:0]                   en5;            // {l_en, r_en} of sampled channel
    slot_t                        slot_q;         // Stage IV channel
    slot_t                        slot5;
    pcm_t                         scaled;

    adpcm_db_rom u_rom (
        .clk (clk),
        .cen (cen),
        .db  (db2[LVL_W-1:0]),
        .lin (lin3)
    );

    // Back to unity weight
    assign scaled = pcm_t'(mul5 >>> GAIN_SHIFT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctl1     <= '0;
            ctl2     <= '0;
            ctl3     <= '0;
            ctl4     <= '0;
            ctl5     <= '0;
            ctl6     <= '0;
            db2      <= '1;     // Muted
            db3      <= '1;
            gain4    <= '0;
            mul5     <= '0;
            en5      <= '0;
            slot_q   <= '0;
            slot5    <= '0;
            out_l    <= '0;
            out_r    <= '0;
            out_slot <= '0;
        end else if (cen) begin
            // I: 63-level plus 63-tl
            ctl2 <= ctl1;
            db2  <= {1'b0, ~ctl1.level} + {1'b0, ~tl};
            // II: ROM address
            ctl3 <= ctl2;
            db3  <= db2;
            // III: 64 or more is silence
            ctl4  <= ctl3;
            gain4 <= db3[ATT_W-1] ? '0 : lin3;
            // IV: sample in, CPU byte in
            ctl5  <= load ? load_ctl : ctl4;
            mul5  <= pcm_in * $signed({1'b0, gain4});
            en5   <= {ctl4.l_en, ctl4.r_en};    // Old byte pans this sample
            slot5 <= slot_q;
            slot_q <= (slot_q == slot_t'(NUM_CH - 1)) ? '0 : slot_q + 1'b1;
            // V: scale and route
            ctl6     <= ctl5;
            out_l    <= en5[1] ? scaled : '0;
            out_r    <= en5[0] ? scaled : '0;
            out_slot <= slot5;
            // VI: close the ring
            ctl1 <= ctl6;
        end
    end

    // Results change only on cen edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_stb <= 1'b0;
        end else begin
            out_stb <= cen;
        end
    end

    assign slot = slot_q;

    a_slot_range: assert property (@(posedge clk) disable iff (!rst_n)
        slot_q < NUM_CH);

    // One strobe per step of the ring
    a_stb_cen: assert property (@(posedge clk) disable iff (!rst_n)
        out_stb == (slot_q != $past(slot_q)));

endmodule

// File: hdl/adpcm_mixer.sv
// Stereo mixer: sums the per-slot gain results of one rotation into a saturated 16-bit frame
`timescale 1ns/1ps

module adpcm_mixer import adpcm_pkg::*; #(
    parameter int NUM_CH = adpcm_pkg::NUM_CH
) (
    input  logic  clk,
    input  logic  rst_n,
    input  pcm_t  out_l,
    input  pcm_t  out_r,
    input  logic  out_stb,      // Slot result valid
    input  slot_t out_slot,
    output pcm_t  mix_l,
    output pcm_t  mix_r,
    output logic  mix_valid     // One pulse per frame
);

    logic signed [SUM_W-1:0] acc_l, acc_r;      // Running sums
    logic signed [SUM_W-1:0] base_l, base_r;
    logic signed [SUM_W-1:0] nxt_l, nxt_r;      // Sums including this slot
    logic                    first;
    logic                    last;
    slot_t                   last_slot;         // Previous strobed slot

    // Clamp to the 16-bit range
    function automatic pcm_t sat(input logic signed [SUM_W-1:0] s);
        logic [SUM_W-PCM_W:0] top;
        top = s[SUM_W-1:PCM_W-1];
        if (top == '0 || top == '1) begin
            return s[PCM_W-1:0];                // In range
        end else if (s[SUM_W-1]) begin
            return {1'b1, {(PCM_W-1){1'b0}}};   // Most negative
        end else begin
            return {1'b0, {(PCM_W-1){1'b1}}};   // Most positive
        end
    endfunction

    assign first = (out_slot == '0);
    assign last  = (out_slot == slot_t'(NUM_CH - 1));

    // Slot 0 starts a new frame
    assign base_l = first ? '0 : acc_l;
    assign base_r = first ? '0 : acc_r;
    assign nxt_l  = base_l + {{(SUM_W-PCM_W){out_l[PCM_W-1]}}, out_l};
    assign nxt_r  = base_r + {{(SUM_W-PCM_W){out_r[PCM_W-1]}}, out_r};

    always_ff @(posedge clk) begin
        if (out_stb) begin
            acc_l <= nxt_l;
            acc_r <= nxt_r;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mix_l     <= '0;
            mix_r     <= '0;
            mix_valid <= 1'b0;
            last_slot <= '0;
        end else begin
            mix_valid <= out_stb && last;   // Lines up with the new frame
            if (out_stb) begin
                last_slot <= out_slot;
                if (last) begin
                    mix_l <= sat(nxt_l);
                    mix_r <= sat(nxt_r);
                end
            end
        end
    end

    // Gain pipeline must deliver slots in rotation order
    a_slot_order: assert property (@(posedge clk) disable iff (!rst_n)
        out_stb && out_slot != '0 |-> out_slot == last_slot + 1'b1);

endmodule

// File: hdl/adpcm_gain_top.sv
// Top level of the ADPCM-A gain and pan stage: CPU registers, gain pipeline and stereo mixer
`timescale 1ns/1ps

module adpcm_gain_top import adpcm_pkg::*; #(
    parameter int NUM_CH = adpcm_pkg::NUM_CH
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,         // Pipeline step enable
    input  logic       wr,          // CPU write strobe
    input  logic [3:0] addr,
    input  reg_data_u  din,
    input  pcm_t       pcm_in,      // Sample for slot
    output slot_t      slot,
    output pcm_t       mix_l,
    output pcm_t       mix_r,
    output logic       mix_valid
);

    logic             load;
    chan_ctl_t        load_ctl;
    logic [LVL_W-1:0] tl;
    pcm_t             out_l;        // Per-slot results
    pcm_t             out_r;
    logic             out_stb;
    slot_t            out_slot;

    adpcm_ctl_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .wr       (wr),
        .addr     (addr),
        .din      (din),
        .slot     (slot),
        .load     (load),
        .load_ctl (load_ctl),
        .tl       (tl)
    );

    adpcm_gain #(
        .NUM_CH (NUM_CH)
    ) u_gain (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .load     (load),
        .load_ctl (load_ctl),
        .tl       (tl),
        .pcm_in   (pcm_in),
        .slot     (slot),
        .out_l    (out_l),
        .out_r    (out_r),
        .out_stb  (out_stb),
        .out_slot (out_slot)
    );

    adpcm_mixer #(
        .NUM_CH (NUM_CH)
    ) u_mix (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_l     (out_l),
        .out_r     (out_r),
        .out_stb   (out_stb),
        .out_slot  (out_slot),
        .mix_l     (mix_l),
        .mix_r     (mix_r),
        .mix_valid (mix_valid)
    );

endmodule

// File: tests/tb_adpcm_gain.sv
// Self-checking testbench for the gain and pan top level; applies a table of control and sample sets
`timescale 1ns/1ps

module tb_adpcm_gain import adpcm_pkg::*; ();

    localparam int CLK_HALF   = 10;             // 20 ns period
    localparam int IN_DELAY   = 2;              // Inputs change after the edge
    localparam int RST_CYC    = 10;
    localparam int NUM_ROWS   = 7;
    // Forty rotations per row plus the idle check and reset
    localparam int TIMEOUT_NS = (NUM_ROWS + 1) * 40 * NUM_CH * 2 * CLK_HALF
                                + RST_CYC * 2 * CLK_HALF;

    // One test set, channel 5 leftmost in the packed fields
    typedef struct packed {
        chan_ctl_t [NUM_CH-1:0] ctl;
        logic [LVL_W-1:0]       tl;
        pcm_t [NUM_CH-1:0]      pcm;
        logic                   rnd_cen;        // Random cen pattern
    } row_t;

    logic       clk;
    logic       rst_n;
    logic       cen;
    logic       wr;
    logic [3:0] addr;
    reg_data_u  din;
    pcm_t       pcm_in;
    slot_t      slot;
    pcm_t       mix_l;
    pcm_t       mix_r;
    logic       mix_valid;

    row_t rows [NUM_ROWS];
    pcm_t cur_pcm [NUM_CH];                     // Samples offered per slot
    logic rnd_mode;
    int   seed = 32'h9abc;

    adpcm_gain_top #(
        .NUM_CH (NUM_CH)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .wr        (wr),
        .addr      (addr),
        .din       (din),
        .pcm_in    (pcm_in),
        .slot      (slot),
        .mix_l     (mix_l),
        .mix_r     (mix_r),
        .mix_valid (mix_valid)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Step enable and the sample for the slot now at stage IV
    initial begin
        cen    = 1'b0;
        pcm_in = '0;
        forever begin
            @(posedge clk);
            #IN_DELAY;
            cen    = rnd_mode ? 1'($random(seed)) : 1'b1;
            pcm_in = cur_pcm[slot];
        end
    end

    // Linear gain from attenuation steps of 0.75 dB
    function automatic int gain_of(input int att);
        real g;
        if (att >= 64) begin
            return 0;                           // Silence
        end
        g = 512.0 * (10.0 ** (-0.0375 * real'(att)));
        return $rtoi(g + 0.5);
    endfunction

    function automatic pcm_t clamp16(input longint s);
        if (s > 32767) begin
            return 16'sh7FFF;
        end else if (s < -32768) begin
            return 16'sh8000;
        end
        return pcm_t'(s);
    endfunction

    // Reference frame for one row
    task automatic compute_frame(input row_t r, output pcm_t exp_l, output pcm_t exp_r);
        longint sum_l;
        longint sum_r;
        longint part;
        int     att;
        pcm_t   smp;
        sum_l = 0;
        sum_r = 0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            att  = (63 - int'(r.ctl[ch].level)) + (63 - int'(r.tl));
            smp  = r.pcm[ch];                   // Signed sample
            part = (longint'(smp) * gain_of(att)) >>> GAIN_SHIFT;
            if (r.ctl[ch].l_en) begin
                sum_l += part;
            end
            if (r.ctl[ch].r_en) begin
                sum_r += part;
            end
        end
        exp_l = clamp16(sum_l);
        exp_r = clamp16(sum_r);
    endtask

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_pcm(input string name, input pcm_t exp, input pcm_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %b, actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_slot(input string name, input slot_t exp, input slot_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Slot counter from reset, one step per cen edge
    initial begin
        slot_t exp_slot;
        exp_slot = '0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            check_slot("slot", exp_slot, slot);
            if (cen) begin
                exp_slot = slot_t'((int'(exp_slot) + 1) % NUM_CH);  // 0 to 5 and round
            end
        end
    end

    // One CPU write, strobe held for a single clock
    task automatic write_reg(input logic [3:0] a, input reg_data_u d);
        @(posedge clk);
        #IN_DELAY;
        wr   = 1'b1;
        addr = a;
        din  = d;
        @(posedge clk);
        #IN_DELAY;
        wr = 1'b0;
    endtask

    task automatic wait_cen(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk);
            if (cen) begin
                seen++;
            end
        end
    endtask

    // Stops on the negedge where the next frame is valid
    task automatic wait_frame();
        do begin
            @(negedge clk);
        end while (!mix_valid);
    endtask

    // cen always high, so a frame every six clocks
    task automatic check_spacing(input pcm_t exp_l, input pcm_t exp_r);
        for (int i = 1; i < NUM_CH; i++) begin
            @(negedge clk);
            check_bit("mix_valid", 1'b0, mix_valid);
        end
        @(negedge clk);
        check_bit("mix_valid", 1'b1, mix_valid);
        check_pcm("mix_l", exp_l, mix_l);
        check_pcm("mix_r", exp_r, mix_r);
    endtask

    task automatic fill_table();
        // Levels 63 down to 47, attenuation 0 to 16, tl loudest
        rows[0] = '{ctl: {8'hEF, 8'hF7, 8'hF8, 8'hFD, 8'hFE, 8'hFF}, tl: 6'd63,
            pcm: {-16'sd6000, 16'sd5000, -16'sd4000, 16'sd3000, -16'sd2000, 16'sd1000},
            rnd_cen: 1'b0};
        // Pan: L, R, both, none, L at 59, R at 55
        rows[1] = '{ctl: {8'h77, 8'hBB, 8'h3F, 8'hFF, 8'h7F, 8'hBF}, tl: 6'd63,
            pcm: {16'sd6666, -16'sd5555, 16'sd4444, 16'sd3333, -16'sd2222, 16'sd1111},
            rnd_cen: 1'b0};
        // tl 55 adds 8 steps, channel 5 reaches 64
        rows[2] = '{ctl: {8'hC7, 8'hC8, 8'hE7, 8'hEF, 8'hFB, 8'hFF}, tl: 6'd55,
            pcm: {16'sd30000, -16'sd30000, 16'sd25000, -16'sd25000, 16'sd20000, 16'sh7FFF},
            rnd_cen: 1'b0};
        // Positive full scale on all six
        rows[3] = '{ctl: {NUM_CH{8'hFF}}, tl: 6'd63, pcm: {NUM_CH{16'sh7FFF}},
            rnd_cen: 1'b0};
        // Negative full scale, gaps in cen
        rows[4] = '{ctl: {NUM_CH{8'hFF}}, tl: 6'd63, pcm: {NUM_CH{16'sh8000}},
            rnd_cen: 1'b1};
        // Mixed pans, tl 43, attenuation 20 to 63
        rows[5] = '{ctl: {8'hD4, 8'hE3, 8'hEB, 8'h73, 8'hB5, 8'hFF}, tl: 6'd43,
            pcm: {-16'sd20000, 16'sd31000, 16'sd9999, -16'sd31000, 16'sd23456, -16'sd12345},
            rnd_cen: 1'b1};
        // tl 0, only level 63 is left at 63 steps
        rows[6] = '{ctl: {8'hFF, 8'hFE, 8'hC0, 8'hBF, 8'h7F, 8'hFF}, tl: 6'd0,
            pcm: {16'sh7FFF, 16'sh7FFF, 16'sh8000, -16'sd1000, 16'sh8000, 16'sd30000},
            rnd_cen: 1'b1};
    endtask

    // Ring is all zero after reset, whatever the samples
    task automatic check_idle();
        wait_frame();
        check_pcm("mix_l", '0, mix_l);
        check_pcm("mix_r", '0, mix_r);
        check_spacing('0, '0);
    endtask

    task automatic run_row(input int idx);
        row_t      r;
        reg_data_u d;
        pcm_t      exp_l;
        pcm_t      exp_r;
        r        = rows[idx];
        rnd_mode = r.rnd_cen;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            cur_pcm[ch] = r.pcm[ch];
        end
        for (int ch = 0; ch < NUM_CH; ch++) begin
            d.ch = r.ctl[ch];                   // Channel view of the byte
            write_reg(4'(ch), d);
        end
        d.tot.pad = 2'b00;
        d.tot.tl  = r.tl;                       // Total level view
        write_reg(TL_ADDR, d);
        wait_cen(2 * NUM_CH);                   // Loads and their next visits
        wait_cen(NUM_CH);                       // Old samples leave the frame
        compute_frame(r, exp_l, exp_r);
        wait_frame();
        check_pcm("mix_l", exp_l, mix_l);
        check_pcm("mix_r", exp_r, mix_r);
        if (!r.rnd_cen) begin
            check_spacing(exp_l, exp_r);
        end
        $display("Row %0d done: mix_l %0d mix_r %0d", idx, mix_l, mix_r);
    endtask

    initial begin
        rst_n    = 1'b0;
        wr       = 1'b0;
        addr     = '0;
        din      = '0;
        rnd_mode = 1'b0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            cur_pcm[ch] = pcm_t'(1000 * (ch + 1));
        end
        fill_table();
        repeat (RST_CYC) @(posedge clk);
        #IN_DELAY;
        rst_n = 1'b1;
        check_idle();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("STATUS: PASS");
        $finish;
    end

    // Ends a run that stops producing frames
    initial begin
        #TIMEOUT_NS;
        $display("Watchdog expired after %0d ns without finishing the table", TIMEOUT_NS);
        abort_run();
    end

endmodule

// File: verilog.f
hdl/adpcm_pkg.sv
hdl/adpcm_db_rom.sv
hdl/adpcm_ctl_regs.sv
hdl/adpcm_gain.sv
hdl/adpcm_mixer.sv
hdl/adpcm_gain_top.sv
tests/tb_adpcm_gain.sv

// File: run_sim.sh
#!/bin/sh
# Builds the gain stage testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtb_adpcm_gain

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_adpcm_gain -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0
